// ==== Bender.yml ====
package:
  name: alu

sources:
  - common/alu_pkg.sv
  - common/alu_unit_if.sv
  - alu_core/alu_arith.sv
  - alu_core/alu_shift.sv
  - divider/alu_div.sv
  - verilog/alu_flags.sv
  - verilog/alu_seq.sv
  - verilog/alu_top.sv
  - target: test
    files:
      - test/alu_chk.sv
      - test/alu_tb.sv

// ==== all.f ====
common/alu_pkg.sv
common/alu_unit_if.sv
alu_core/alu_arith.sv
alu_core/alu_shift.sv
divider/alu_div.sv
verilog/alu_flags.sv
verilog/alu_seq.sv
verilog/alu_top.sv
test/alu_chk.sv
test/alu_tb.sv

// ==== alu_core/alu_arith.sv ====
// ==========================================================
// Add, subtract and logic unit
// nibble carry chain, flags per width, one-cycle result
// ==========================================================
`timescale 1ns/1ps

module alu_arith (
    input  logic     clk,
    input  logic     rst,
    alu_unit_if.unit bus
);
    import alu_pkg::*;

    logic       is_sub;
    logic       is_logic;
    logic       cin;
    logic [8:0] cy;       // carry into each nibble
    logic       cout;
    logic       ovf;
    data_t      bb;       // b, inverted for subtract
    data_t      sum;
    data_t      lres;
    data_t      r;
    flag_vec_t  f;

    always_comb begin
        is_sub   = bus.op inside {ALU_SUB, ALU_SBC, ALU_CP};
        is_logic = bus.op inside {ALU_AND, ALU_OR, ALU_XOR};
        cin      = bus.op inside {ALU_ADC, ALU_SBC} && bus.flags_in[F_C];
        bb       = is_sub ? ~bus.b : bus.b;
        cy[0]    = is_sub ? ~cin : cin;   // a + ~b + ~borrow
        for (int i = 0; i < 8; i++) begin
            {cy[i+1], sum[4*i +: 4]} = {1'b0, bus.a[4*i +: 4]}
                                     + {1'b0, bb[4*i +: 4]} + {4'd0, cy[i]};
        end
        case (bus.width)
            BYTE:    cout = cy[2];
            WORD:    cout = cy[4];
            default: cout = cy[8];
        endcase
        ovf = sign_of(bus.a, bus.width) == sign_of(bb, bus.width)
              && sign_of(sum, bus.width) != sign_of(bus.a, bus.width);
        case (bus.op)
            ALU_AND: lres = bus.a & bus.b;
            ALU_OR:  lres = bus.a | bus.b;
            default: lres = bus.a ^ bus.b;
        endcase
        r = mask_w(is_logic ? lres : sum, bus.width);

        f[F_S] = sign_of(r, bus.width);
        f[F_Z] = zero_of(r, bus.width);
        f[F_H] = is_logic ? bus.op == ALU_AND : cy[1] ^ is_sub;
        f[F_V] = is_logic ? parity_of(r, bus.width) : ovf;
        f[F_N] = is_sub;
        f[F_C] = is_logic ? 1'b0 : cout ^ is_sub;   // borrow for subtract
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            bus.ack <= 1'b0;
        else
            bus.ack <= bus.go;
    end

    always_ff @(posedge clk) begin
        if (bus.go) begin
            bus.res       <= r;
            bus.flags_out <= f;
        end
    end

endmodule

// ==== alu_core/alu_shift.sv ====
// ==========================================================
// Shift and rotate unit
// one bit per cycle, count 1 to 16 from b[3:0]
// ==========================================================
`timescale 1ns/1ps

module alu_shift (
    input  logic     clk,
    input  logic     rst,
    alu_unit_if.unit bus
);
    import alu_pkg::*;

    shift_cnt_t cnt;
    shift_cnt_t eff;      // effective count of a new request
    logic       run;
    data_t      val;
    logic       cy;       // last bit shifted out
    alu_op_t    op_q;
    width_t     w_q;
    alu_op_t    cur_op;
    width_t     cur_w;
    data_t      src;
    logic       c_src;
    data_t      nxt;
    logic       c_nxt;
    logic       fill;

    always_comb begin
        cur_op = bus.go ? bus.op : op_q;
        cur_w  = bus.go ? bus.width : w_q;
        src    = bus.go ? mask_w(bus.a, bus.width) : val;
        c_src  = bus.go ? bus.flags_in[F_C] : cy;
        eff    = (bus.b[3:0] == 4'd0) ? shift_cnt_t'(SHIFT_CNT_ZERO_MEANS)
                                      : {1'b0, bus.b[3:0]};
        fill   = 1'b0;
        if (cur_op inside {ALU_RLC, ALU_RL, ALU_SLA, ALU_SLL}) begin
            c_nxt = src[msb_of(cur_w)];
            if (cur_op == ALU_RLC)
                fill = c_nxt;                   // wrap around
            else if (cur_op == ALU_RL)
                fill = c_src;                   // through carry
            nxt = mask_w({src[DATA_W-2:0], fill}, cur_w);
        end else begin
            c_nxt = src[0];
            case (cur_op)
                ALU_RRC: fill = src[0];
                ALU_RR:  fill = c_src;
                ALU_SRA: fill = src[msb_of(cur_w)];   // keep sign
                default: fill = 1'b0;
            endcase
            nxt = src >> 1;
            nxt[msb_of(cur_w)] = fill;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run     <= 1'b0;
            cnt     <= '0;
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= 1'b0;
            if (bus.go) begin   // first step on the request edge
                cnt     <= eff - 5'd1;
                run     <= eff != 5'd1;
                bus.ack <= eff == 5'd1;
            end else if (run) begin
                cnt <= cnt - 5'd1;
                if (cnt == 5'd1) begin
                    run     <= 1'b0;
                    bus.ack <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.go || run) begin
            val <= nxt;
            cy  <= c_nxt;
        end
        if (bus.go) begin
            op_q <= bus.op;
            w_q  <= bus.width;
        end
    end

    assign bus.res       = val;
    assign bus.flags_out = {sign_of(val, w_q), zero_of(val, w_q), 1'b0,
                            parity_of(val, w_q), 1'b0, cy};

endmodule

// ==== common/alu_pkg.sv ====
// ==========================================================
// ALU package
// operation and width enums, data and flag vector types,
// flag bit positions and width helper functions
// ==========================================================
package alu_pkg;

    localparam int DATA_W               = 32;
    localparam int SHIFT_CNT_ZERO_MEANS = 16;  // count field 0 selects 16 steps

    // bit positions inside flag_vec_t
    localparam int F_S = 5;
    localparam int F_Z = 4;
    localparam int F_H = 3;
    localparam int F_V = 2;
    localparam int F_N = 1;
    localparam int F_C = 0;

    typedef enum logic [5:0] {
        ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_CP,
        ALU_AND, ALU_OR,  ALU_XOR,
        ALU_RLC, ALU_RRC, ALU_RL,  ALU_RR,
        ALU_SLA, ALU_SRA, ALU_SLL, ALU_SRL,
        ALU_DIV, ALU_DIVS,
        ALU_CCF, ALU_SCF, ALU_RCF, ALU_EXFF
    } alu_op_t;

    typedef enum logic [1:0] {BYTE, WORD, LONG} width_t;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [5:0]        flag_vec_t;   // s z h v n c
    typedef logic [7:0]        flag_byte_t;
    typedef logic [4:0]        shift_cnt_t;

    function automatic logic [4:0] msb_of(width_t w);
        case (w)
            BYTE:    return 5'd7;
            WORD:    return 5'd15;
            default: return 5'd31;
        endcase
    endfunction

    function automatic data_t mask_w(data_t r, width_t w);
        case (w)
            BYTE:    return {24'd0, r[7:0]};
            WORD:    return {16'd0, r[15:0]};
            default: return r;
        endcase
    endfunction

    function automatic logic sign_of(data_t r, width_t w);
        return r[msb_of(w)];
    endfunction

    function automatic logic zero_of(data_t r, width_t w);
        return mask_w(r, w) == '0;
    endfunction

    // even parity over the low byte or the low half-word
    function automatic logic parity_of(data_t r, width_t w);
        return (w == BYTE) ? ~^r[7:0] : ~^r[15:0];
    endfunction

endpackage

// ==== common/alu_unit_if.sv ====
// ==========================================================
// ALU unit interface
// go/ack handshake, operands and flags between the
// sequencer and one execution unit
// ==========================================================
`timescale 1ns/1ps

interface alu_unit_if;
    import alu_pkg::*;

    logic      go;         // one-cycle request
    alu_op_t   op;
    width_t    width;
    data_t     a;
    data_t     b;
    flag_vec_t flags_in;   // flags before the operation
    logic      ack;        // one-cycle, res valid from here on
    data_t     res;
    flag_vec_t flags_out;

    modport ctrl (
        output go, op, width, a, b, flags_in,
        input  ack, res, flags_out
    );

    modport unit (
        input  go, op, width, a, b, flags_in,
        output ack, res, flags_out
    );

endinterface

// ==== divider/alu_div.sv ====
// ==========================================================
// Restoring divider
// 16/8 and 32/16, unsigned and signed, overflow and
// divide-by-zero detection in V
// ==========================================================
`timescale 1ns/1ps

module alu_div (
    input  logic     clk,
    input  logic     rst,
    alu_unit_if.unit bus
);
    import alu_pkg::*;

    typedef enum logic [1:0] {D_IDLE, D_STEP, D_FIX} div_state_t;

    div_state_t  state;
    shift_cnt_t  cnt;
    logic [15:0] r;        // partial remainder
    data_t       q;        // dividend bits out, quotient bits in
    logic [15:0] dvs;      // divisor magnitude
    logic [15:0] dlo;      // dividend low half
    logic        byte_q;
    logic        sgn_q;
    logic        qneg;
    logic        rneg;
    logic        dz;
    logic        ovf_hi;   // high half not below divisor
    flag_vec_t   fl_q;

    logic        sgn;
    logic        is_b;
    data_t       dd_ext;
    logic [15:0] dv_ext;
    data_t       dd_mag;
    logic [15:0] dv_mag;
    logic [15:0] r_init;
    logic [17:0] diff;
    logic [15:0] r_nxt;
    data_t       q_nxt;

    always_comb begin
        sgn    = bus.op == ALU_DIVS;
        is_b   = bus.width == BYTE;
        dd_ext = is_b ? {{16{sgn & bus.a[15]}}, bus.a[15:0]} : bus.a;
        dv_ext = is_b ? {{8{sgn & bus.b[7]}}, bus.b[7:0]} : bus.b[15:0];
        dd_mag = (sgn && dd_ext[DATA_W-1]) ? -dd_ext : dd_ext;
        dv_mag = (sgn && dv_ext[15]) ? -dv_ext : dv_ext;
        r_init = is_b ? {8'd0, dd_mag[15:8]} : dd_mag[31:16];

        diff  = {1'b0, r, q[DATA_W-1]} - {2'b00, dvs};
        r_nxt = diff[17] ? {r[14:0], q[DATA_W-1]} : diff[15:0];   // restore
        q_nxt = {q[DATA_W-2:0], ~diff[17]};
    end

    function automatic data_t pack(logic [15:0] rr, data_t qq);
        logic [15:0] qf;
        logic [15:0] rf;
        qf = byte_q ? {8'd0, qq[7:0]} : qq[15:0];
        rf = byte_q ? {8'd0, rr[7:0]} : rr;
        qf = qneg ? -qf : qf;
        rf = rneg ? -rf : rf;
        if (dz) begin
            qf = '1;
            rf = dlo;
        end
        return byte_q ? {16'd0, rf[7:0], qf[7:0]} : {rf, qf};
    endfunction

    function automatic flag_vec_t div_flags(data_t qq);
        flag_vec_t f;
        logic      top;
        logic      rest0;
        top    = byte_q ? qq[7] : qq[15];
        rest0  = byte_q ? qq[6:0] == '0 : qq[14:0] == '0;
        f      = fl_q;
        f[F_V] = ovf_hi || (sgn_q && top && !(qneg && rest0));   // signed range
        return f;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= D_IDLE;
            cnt     <= '0;
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= 1'b0;
            case (state)
                D_IDLE: if (bus.go) begin
                    state <= D_STEP;
                    cnt   <= is_b ? 5'd8 : 5'd16;
                end
                D_STEP: begin
                    cnt <= cnt - 5'd1;
                    if (cnt == 5'd1) begin
                        state   <= sgn_q ? D_FIX : D_IDLE;
                        bus.ack <= !sgn_q;
                    end
                end
                D_FIX: begin
                    state   <= D_IDLE;
                    bus.ack <= 1'b1;
                end
                default: state <= D_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == D_IDLE && bus.go) begin
            r      <= r_init;
            q      <= is_b ? {dd_mag[7:0], 24'd0} : {dd_mag[15:0], 16'd0};
            dvs    <= dv_mag;
            dlo    <= is_b ? {8'd0, bus.a[7:0]} : bus.a[15:0];
            byte_q <= is_b;
            sgn_q  <= sgn;
            qneg   <= sgn && (dd_ext[DATA_W-1] ^ dv_ext[15]);
            rneg   <= sgn && dd_ext[DATA_W-1];   // remainder follows dividend
            dz     <= dv_mag == '0;
            ovf_hi <= r_init >= dv_mag;
            fl_q   <= bus.flags_in;
        end else if (state == D_STEP) begin
            r <= r_nxt;
            q <= q_nxt;
            if (cnt == 5'd1 && !sgn_q) begin
                bus.res       <= pack(r_nxt, q_nxt);
                bus.flags_out <= div_flags(q_nxt);
            end
        end else if (state == D_FIX) begin
            bus.res       <= pack(r, q);
            bus.flags_out <= div_flags(q);
        end
    end

endmodule

// ==== test/alu_chk.sv ====
// ==========================================================
// ALU handshake checker
// concurrent assertions on start, busy and done,
// bound into alu_top
// ==========================================================
`timescale 1ns/1ps

module alu_chk (
    input logic clk,
    input logic rst,
    input logic start,
    input logic busy,
    input logic done
);

    int fail_count = 0;   // failed assertions so far

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            $error("done held high for more than one cycle");
            fail_count++;
        end

    a_done_idle: assert property (@(posedge clk) disable iff (rst) !(done && busy))
        else begin
            $error("done and busy high together");
            fail_count++;
        end

    // an accepted start turns into busy on the next edge
    a_done_cause: assert property (@(posedge clk) disable iff (rst)
        done |-> $past(busy) || $past(start && !busy))
        else begin
            $error("done without a running operation");
            fail_count++;
        end

    a_reset_clear: assert property (@(posedge clk) $fell(rst) |-> !busy && !done)
        else begin
            $error("busy or done high after reset");
            fail_count++;
        end

endmodule

bind alu_top alu_chk i_alu_chk (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .busy  (busy),
    .done  (done)
);

// ==== test/alu_input.txt ====
# op width opa opb result flags test  (op, width, test in decimal; the rest in hex)
# op 0-7 ADD ADC SUB SBC CP AND OR XOR, 8-15 RLC RRC RL RR SLA SRA SLL SRL, 16 DIV 17 DIVS, 18-21 CCF SCF RCF EXFF
0 0 0000007F 00000001 00000080 94 1
0 0 000000FF 00000001 00000000 51 2
1 1 00001234 00000FFF 00002234 10 3
2 1 00001000 00000001 00000FFF 12 4
2 0 00000000 00000001 000000FF 93 5
3 2 80000000 00000000 7FFFFFFF 16 6
4 0 00000005 00000005 7FFFFFFF 42 7
0 2 89ABCDEF 76543211 00000000 51 8
5 0 000000F0 0000003C 00000030 14 9
6 1 00008000 00000001 00008001 84 10
7 2 12345678 12345679 00000001 00 11
8 0 00000081 00000001 00000003 05 12
9 1 00000001 00000005 00000800 00 13
10 0 00000080 00000001 00000000 45 14
11 0 00000001 00000005 00000018 04 15
12 1 00004001 00000000 00000000 45 16
13 0 00000090 00000005 000000FC 85 17
14 2 40000001 00000001 80000002 80 18
15 1 00008001 00000010 00000000 45 19
16 0 00000064 00000007 0000020E 41 20
17 0 0000FF9C 00000007 0000FEF2 41 21
17 0 000000C8 00000001 000000C8 45 22
17 1 FFFFFC18 0000FFF9 FFFA008E 41 23
16 1 00010000 00000000 0000FFFF 45 24
2 0 00000080 00000001 0000007F 16 25
19 0 00000000 00000000 0000007F 05 26
18 0 00000000 00000000 0000007F 04 27
20 0 00000000 00000000 0000007F 04 28
21 0 00000000 00000000 0000007F 00 29
21 0 00000000 00000000 0000007F 04 30

// ==== test/alu_tb.sv ====
// ==========================================================
// ALU testbench
// reads vectors from test/alu_input.txt, drives the DUT,
// checks result, flags, latency and start while busy
// ==========================================================
`timescale 1ns/1ps

module alu_tb;
    import alu_pkg::*;

    localparam int WAIT_LIMIT = 100;   // cycles allowed per wait loop

    logic       clk;
    logic       rst;
    logic       start;
    alu_op_t    op;
    width_t     width;
    data_t      opa;
    data_t      opb;
    logic       busy;
    logic       done;
    data_t      result;
    flag_byte_t flags;

    int tests;
    int failed;
    int errors;     // failed checks over the whole run
    bit aborted;    // timeout or unreadable vector file

    alu_top i_alu_top (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .op     (op),
        .width  (width),
        .opa    (opa),
        .opb    (opb),
        .busy   (busy),
        .done   (done),
        .result (result),
        .flags  (flags)
    );

    always #20 clk = ~clk;

    task automatic wait_idle(input int num);
        int cycles;
        cycles = 0;
        while (busy && !aborted) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("Timeout: busy stuck high before test %0d", num);
                aborted = 1'b1;
            end
        end
    endtask

    // a division also gets a stray start while it runs
    task automatic wait_done(input int num, input alu_op_t vop, output int cycles);
        cycles = 0;
        while (!done && !aborted) begin
            assert (busy) else begin
                $display("Fail %0t ns: test %0d %s busy low before done", $time, num, vop.name());
                errors++;
            end
            @(posedge clk);
            #2;
            cycles++;
            if (vop inside {ALU_DIV, ALU_DIVS}) begin
                if (cycles == 2) begin
                    start = 1'b1;
                    op    = ALU_ADD;
                    opa   = 32'hFFFF_FFFF;
                    opb   = 32'h0000_0001;
                end else if (cycles == 3) begin
                    start = 1'b0;
                end
            end
            if (cycles > WAIT_LIMIT) begin
                $display("Timeout: test %0d %s never raised done", num, vop.name());
                aborted = 1'b1;
            end
        end
    endtask

    task automatic run_vector(input int v_op, input int v_w, input data_t a, input data_t b,
                              input data_t exp_res, input flag_byte_t exp_flags, input int num);
        alu_op_t vop;
        int      cycles;
        int      err_before;
        vop        = alu_op_t'(v_op);
        err_before = errors;
        wait_idle(num);
        if (aborted)
            return;
        start = 1'b1;
        op    = vop;
        width = width_t'(v_w);
        opa   = a;
        opb   = b;
        @(posedge clk);   // accepting edge
        #2;
        start = 1'b0;
        wait_done(num, vop, cycles);
        if (aborted)
            return;
        assert (result === exp_res) else begin
            $display("Fail %0t ns: test %0d %s result %h, expected %h",
                     $time, num, vop.name(), result, exp_res);
            errors++;
        end
        assert (flags === exp_flags) else begin
            $display("Fail %0t ns: test %0d %s flags %h, expected %h",
                     $time, num, vop.name(), flags, exp_flags);
            errors++;
        end
        if (vop inside {ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_CP, ALU_AND, ALU_OR,
                        ALU_XOR, ALU_CCF, ALU_SCF, ALU_RCF, ALU_EXFF}) begin
            assert (cycles == 1) else begin
                $display("Fail %0t ns: test %0d %s done after %0d cycles, expected 1",
                         $time, num, vop.name(), cycles);
                errors++;
            end
        end
        if (vop inside {ALU_DIV, ALU_DIVS}) begin
            @(posedge clk);   // the stray start must not have been queued
            #2;
            assert (!busy) else begin
                $display("Fail %0t ns: test %0d %s busy again after done",
                         $time, num, vop.name());
                errors++;
            end
        end
        tests++;
        if (errors != err_before)
            failed++;
        $display("test %0d %s %s", num, vop.name(), (errors == err_before) ? "ok" : "mismatch");
    endtask

    initial begin
        int         fd;
        int         n;
        string      line;
        int         v_op;
        int         v_w;
        int         v_num;
        data_t      v_a;
        data_t      v_b;
        data_t      v_res;
        flag_byte_t v_fl;
        clk     = 1'b0;
        rst     = 1'b1;
        start   = 1'b0;
        op      = ALU_ADD;
        width   = BYTE;
        opa     = '0;
        opb     = '0;
        tests   = 0;
        failed  = 0;
        errors  = 0;
        aborted = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        assert (busy === 1'b0 && done === 1'b0 && result === '0 && flags === '0) else begin
            $display("Fail %0t ns: outputs not cleared by reset", $time);
            errors++;
        end
        fd = $fopen("test/alu_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open vector file test/alu_input.txt");
            aborted = 1'b1;
        end else begin
            while (!aborted && $fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#")
                    continue;   // blank or comment line
                n = $sscanf(line, "%d %d %h %h %h %h %d",
                            v_op, v_w, v_a, v_b, v_res, v_fl, v_num);
                if (n != 7) begin
                    $display("Malformed vector line: %s", line);
                    errors++;
                end else begin
                    run_vector(v_op, v_w, v_a, v_b, v_res, v_fl, v_num);
                end
            end
            $fclose(fd);
        end
        assert (i_alu_top.i_alu_chk.fail_count == 0) else begin
            $display("Handshake checker saw %0d failed assertions",
                     i_alu_top.i_alu_chk.fail_count);
            errors++;
        end
        $display("%0d tests run, %0d passed, %0d failed", tests, tests - failed, failed);
        if (errors == 0 && !aborted)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== verilog/alu_flags.sv ====
// ==========================================================
// Flag register
// working flags, shadow copy F', flag-only operations
// and the packed status byte
// ==========================================================
`timescale 1ns/1ps

module alu_flags (
    input  logic                clk,
    input  logic                rst,
    input  logic                load,
    input  alu_pkg::flag_vec_t  new_flags,
    input  logic                flag_op,
    input  alu_pkg::alu_op_t    op,
    output alu_pkg::flag_vec_t  cur,
    output alu_pkg::flag_byte_t flags
);
    import alu_pkg::*;

    flag_vec_t shadow;   // F'

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cur    <= '0;
            shadow <= '0;
        end else if (load) begin
            cur <= new_flags;
        end else if (flag_op) begin
            case (op)
                ALU_CCF: cur[F_C] <= ~cur[F_C];
                ALU_SCF: begin
                    cur[F_C] <= 1'b1;
                    cur[F_H] <= 1'b0;
                    cur[F_N] <= 1'b0;
                end
                ALU_RCF: begin
                    cur[F_C] <= 1'b0;
                    cur[F_H] <= 1'b0;
                    cur[F_N] <= 1'b0;
                end
                ALU_EXFF: begin
                    cur    <= shadow;
                    shadow <= cur;
                end
                default: ;
            endcase
        end
    end

    assign flags = {cur[F_S], cur[F_Z], 1'b0, cur[F_H],
                    1'b0, cur[F_V], cur[F_N], cur[F_C]};

endmodule

// ==== verilog/alu_seq.sv ====
// ==========================================================
// ALU sequencer
// accepts one operation, dispatches it to a unit bus,
// holds the result register, drives busy and done
// ==========================================================
`timescale 1ns/1ps

module alu_seq (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  alu_pkg::alu_op_t   op,
    input  alu_pkg::width_t    width,
    input  alu_pkg::data_t     opa,
    input  alu_pkg::data_t     opb,
    output logic               busy,
    output logic               done,
    output alu_pkg::data_t     result,
    alu_unit_if.ctrl           arith,
    alu_unit_if.ctrl           shift,
    alu_unit_if.ctrl           div,
    input  alu_pkg::flag_vec_t cur_flags,
    output logic               flag_load,
    output alu_pkg::flag_vec_t new_flags,
    output logic               flag_op
);
    import alu_pkg::*;

    typedef enum logic [1:0] {IDLE, WAIT_UNIT, FLAG_OP} state_t;
    typedef enum logic [1:0] {U_ARITH, U_SHIFT, U_DIV, U_FLAG} unit_t;

    state_t state;
    unit_t  sel;
    unit_t  sel_q;      // unit in flight
    logic   is_cp;      // compare keeps the old result
    logic   accept;
    logic   unit_ack;
    data_t  unit_res;

    always_comb begin
        case (op)
            ALU_RLC, ALU_RRC, ALU_RL, ALU_RR,
            ALU_SLA, ALU_SRA, ALU_SLL, ALU_SRL: sel = U_SHIFT;
            ALU_DIV, ALU_DIVS:                  sel = U_DIV;
            ALU_CCF, ALU_SCF, ALU_RCF, ALU_EXFF: sel = U_FLAG;
            default:                            sel = U_ARITH;
        endcase
    end

    assign busy    = state != IDLE;
    assign accept  = start && !busy;   // start while busy is dropped
    assign flag_op = accept && sel == U_FLAG;

    assign arith.go       = accept && sel == U_ARITH;
    assign arith.op       = op;
    assign arith.width    = width;
    assign arith.a        = opa;
    assign arith.b        = opb;
    assign arith.flags_in = cur_flags;
    assign shift.go       = accept && sel == U_SHIFT;
    assign shift.op       = op;
    assign shift.width    = width;
    assign shift.a        = opa;
    assign shift.b        = opb;
    assign shift.flags_in = cur_flags;
    assign div.go         = accept && sel == U_DIV;
    assign div.op         = op;
    assign div.width      = width;
    assign div.a          = opa;
    assign div.b          = opb;
    assign div.flags_in   = cur_flags;

    always_comb begin
        case (sel_q)
            U_SHIFT: begin
                unit_ack  = shift.ack;
                unit_res  = shift.res;
                new_flags = shift.flags_out;
            end
            U_DIV: begin
                unit_ack  = div.ack;
                unit_res  = div.res;
                new_flags = div.flags_out;
            end
            default: begin
                unit_ack  = arith.ack;
                unit_res  = arith.res;
                new_flags = arith.flags_out;
            end
        endcase
    end

    assign flag_load = state == WAIT_UNIT && unit_ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= IDLE;
            sel_q  <= U_ARITH;
            is_cp  <= 1'b0;
            done   <= 1'b0;
            result <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: if (accept) begin
                    sel_q <= sel;
                    is_cp <= op == ALU_CP;
                    state <= (sel == U_FLAG) ? FLAG_OP : WAIT_UNIT;
                end
                WAIT_UNIT: if (unit_ack) begin
                    if (!is_cp)
                        result <= unit_res;
                    done  <= 1'b1;
                    state <= IDLE;
                end
                FLAG_OP: begin   // flags already updated on the accepting edge
                    done  <= 1'b1;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== verilog/alu_top.sv ====
// ==========================================================
// ALU top level
// sequencer, flag register and the arithmetic, shift and
// divide units joined by three unit buses
// ==========================================================
`timescale 1ns/1ps

module alu_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  alu_pkg::alu_op_t    op,
    input  alu_pkg::width_t     width,
    input  alu_pkg::data_t      opa,
    input  alu_pkg::data_t      opb,
    output logic                busy,
    output logic                done,
    output alu_pkg::data_t      result,
    output alu_pkg::flag_byte_t flags
);
    import alu_pkg::*;

    flag_vec_t cur_flags;
    flag_vec_t new_flags;
    logic      flag_load;
    logic      flag_op;

    alu_unit_if arith_bus ();
    alu_unit_if shift_bus ();
    alu_unit_if div_bus ();

    alu_seq i_alu_seq (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .op        (op),
        .width     (width),
        .opa       (opa),
        .opb       (opb),
        .busy      (busy),
        .done      (done),
        .result    (result),
        .arith     (arith_bus),
        .shift     (shift_bus),
        .div       (div_bus),
        .cur_flags (cur_flags),
        .flag_load (flag_load),
        .new_flags (new_flags),
        .flag_op   (flag_op)
    );

    alu_flags i_alu_flags (
        .clk       (clk),
        .rst       (rst),
        .load      (flag_load),
        .new_flags (new_flags),
        .flag_op   (flag_op),
        .op        (op),        // sampled on the accepting edge
        .cur       (cur_flags),
        .flags     (flags)
    );

    alu_arith i_alu_arith (.clk(clk), .rst(rst), .bus(arith_bus));
    alu_shift i_alu_shift (.clk(clk), .rst(rst), .bus(shift_bus));
    alu_div   i_alu_div   (.clk(clk), .rst(rst), .bus(div_bus));

endmodule
